// ==== verilog/turf_reg_pkg.sv ====
package turf_reg_pkg;

    //////////////////////////////
    // Register bus shapes
    //////////////////////////////

    localparam int REG_ADDR_W = 28;
    localparam int REG_DATA_W = 32;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] wdata;
        logic                  we;
    } reg_req_t;

    typedef struct packed {
        logic [REG_DATA_W-1:0] rdata;
        logic                  err;
    } reg_resp_t;

    //////////////////////////////
    // Address map
    //////////////////////////////

    // Top address bit selects the crate space
    localparam int CRATE_SPACE_BIT = 27;
    // Bits ID_SPACE_TOP down to ID_OFFS_W must be zero for the ID space
    localparam int ID_SPACE_TOP = 26;
    localparam int ID_OFFS_W    = 14;

    localparam logic [ID_OFFS_W-1:0] ID_OFFS_IDENT          = 14'h00;
    localparam logic [ID_OFFS_W-1:0] ID_OFFS_DATEVERSION    = 14'h04;
    localparam logic [ID_OFFS_W-1:0] ID_OFFS_CONTROL        = 14'h08;
    localparam logic [ID_OFFS_W-1:0] ID_OFFS_BRIDGE_TYPE    = 14'h0C;
    localparam logic [ID_OFFS_W-1:0] ID_OFFS_BRIDGE_INVALID = 14'h10;
    localparam logic [ID_OFFS_W-1:0] ID_OFFS_LINK_UP        = 14'h14;

    //////////////////////////////
    // Identification
    //////////////////////////////

    localparam logic [REG_DATA_W-1:0] TURF_IDENT = 32'h54555246;

    localparam logic        REV_B         = 1'b1;
    localparam logic [14:0] FIRMWARE_DATE = 15'd0;
    localparam logic [3:0]  VER_MAJOR     = 4'd0;
    localparam logic [3:0]  VER_MINOR     = 4'd8;
    localparam logic [7:0]  VER_REV       = 8'd13;

    localparam logic [REG_DATA_W-1:0] TURF_DATEVERSION =
        {REV_B, FIRMWARE_DATE, VER_MAJOR, VER_MINOR, VER_REV};

    // Read data that goes out with every error response
    localparam logic [REG_DATA_W-1:0] ERR_RDATA = 32'hDEADBEEF;

endpackage

// ==== verilog/turf_io_pkg.sv ====
package turf_io_pkg;

    localparam int NUM_TURFIO   = 4;
    localparam int GPO_NUM_SRC  = 4;
    localparam int CRATE_ADDR_W = 25;

    // Bridge used to reach each TURFIO's crate registers
    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_type_e;

    // Codes 4 to 7 select no source
    typedef enum logic [2:0] {
        GPO_SYNC = 3'd0,
        GPO_RUN  = 3'd1,
        GPO_TRIG = 3'd2,
        GPO_PPS  = 3'd3
    } gpo_sel_e;

    typedef struct packed {
        logic ce;
        logic d;
    } gpo_src_t;

    typedef struct packed {
        logic [1:0]              turfio;
        logic [CRATE_ADDR_W-1:0] addr;
        logic [31:0]             wdata;
    } crate_cmd_t;

endpackage

// ==== verilog/reg_skid_buffer.sv ====
`timescale 1ns/1ps
module reg_skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     ps_clk,
    input  logic     reset_i,
    input  payload_t in_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    output payload_t out_o,
    output logic     out_valid_o,
    input  logic     out_ready_i
);

    payload_t out_q;
    payload_t skid_q;
    logic     out_valid_q;
    logic     skid_valid_q;
    logic     out_load;
    logic     in_take;

    // Second entry only fills while the output is stalled
    assign in_ready_o = !skid_valid_q;
    assign in_take    = in_valid_i && in_ready_o;
    assign out_load   = out_ready_i || !out_valid_q;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_load) begin
            out_valid_q  <= skid_valid_q || in_valid_i;
            skid_valid_q <= 1'b0;
        end else if (in_take) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (out_load) begin
            out_q <= skid_valid_q ? skid_q : in_i;
        end else if (in_take) begin
            skid_q <= in_i;
        end
    end

    assign out_o       = out_q;
    assign out_valid_o = out_valid_q;

endmodule

// ==== verilog/reg_space_decode.sv ====
`timescale 1ns/1ps
module reg_space_decode import turf_reg_pkg::*, turf_io_pkg::*; (
    input  logic                  ps_clk,
    input  logic                  reset_i,
    input  reg_req_t              req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output reg_resp_t             resp_o,
    output logic                  resp_valid_o,
    input  logic                  resp_ready_i,
    output logic                  id_wr_o,
    output logic                  id_rd_o,
    output logic [ID_OFFS_W-1:0]  id_offs_o,
    output logic [REG_DATA_W-1:0] id_wdata_o,
    input  logic [REG_DATA_W-1:0] id_rdata_i,
    input  logic                  id_hit_i,
    output crate_cmd_t            crate_req_o,
    output logic                  crate_wr_o,
    input  logic                  crate_done_i,
    input  logic                  crate_err_i
);

    logic      is_crate;
    logic      is_id;
    logic      crate_wr;
    logic      crate_fin;
    logic      crate_bad;
    logic      out_free;
    logic      take;
    logic      crate_held_q;
    logic      crate_err_q;
    logic      resp_valid_q;
    reg_resp_t resp_d;
    reg_resp_t resp_q;

    //////////////////////////////
    // Space decode
    //////////////////////////////

    assign is_crate = req_i.addr[CRATE_SPACE_BIT];
    assign is_id    = !is_crate && (req_i.addr[ID_SPACE_TOP:ID_OFFS_W] == '0);
    assign crate_wr = req_valid_i && is_crate && req_i.we;

    // A crate write that finished while the response stage was full is held here
    assign crate_fin = crate_held_q || crate_done_i || crate_err_i;
    assign crate_bad = crate_held_q ? crate_err_q : crate_err_i;

    assign out_free    = !resp_valid_q || resp_ready_i;
    assign req_ready_o = out_free && (!crate_wr || crate_fin);
    assign take        = req_valid_i && req_ready_o;

    assign id_offs_o  = req_i.addr[ID_OFFS_W-1:0];
    assign id_wdata_o = req_i.wdata;
    assign id_wr_o    = take && is_id && req_i.we;
    assign id_rd_o    = take && is_id && !req_i.we;

    // TURFIO select sits just above the crate offset
    assign crate_req_o = '{turfio: req_i.addr[26:25],
                           addr:   req_i.addr[CRATE_ADDR_W-1:0],
                           wdata:  req_i.wdata};
    assign crate_wr_o  = crate_wr && !crate_held_q;

    always_comb begin
        resp_d.err   = 1'b1;
        resp_d.rdata = ERR_RDATA;
        if (is_id && id_hit_i) begin
            resp_d.err   = 1'b0;
            resp_d.rdata = req_i.we ? '0 : id_rdata_i;
        end else if (is_crate && req_i.we && !crate_bad) begin
            resp_d.err   = 1'b0;
            resp_d.rdata = '0;
        end
    end

    //////////////////////////////
    // Response stage
    //////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            resp_valid_q <= 1'b0;
            crate_held_q <= 1'b0;
            crate_err_q  <= 1'b0;
        end else begin
            if (take) begin
                resp_valid_q <= 1'b1;
            end else if (resp_ready_i) begin
                resp_valid_q <= 1'b0;
            end
            if (take) begin
                crate_held_q <= 1'b0;
            end else if (crate_wr_o && (crate_done_i || crate_err_i)) begin
                crate_held_q <= 1'b1;
                crate_err_q  <= crate_err_i;
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (take) begin
            resp_q <= resp_d;
        end
    end

    assign resp_o       = resp_q;
    assign resp_valid_o = resp_valid_q;

endmodule

// ==== verilog/id_ctrl_regs.sv ====
`timescale 1ns/1ps
module id_ctrl_regs import turf_reg_pkg::*, turf_io_pkg::*; (
    input  logic                            ps_clk,
    input  logic                            reset_i,
    input  logic                            wr_i,
    input  logic                            rd_i,
    input  logic [ID_OFFS_W-1:0]            offs_i,
    input  logic [REG_DATA_W-1:0]           wdata_i,
    output logic [REG_DATA_W-1:0]           rdata_o,
    output logic                            hit_o,
    input  logic [NUM_TURFIO-1:0]           link_up_i,
    input  logic [NUM_TURFIO-1:0]           bridge_invalid_i,
    output bridge_type_e [NUM_TURFIO-1:0]   bridge_type_o,
    output logic                            gpo_en_o,
    output gpo_sel_e                        gpo_sel_o
);

    logic                          gpo_en_q;
    gpo_sel_e                      gpo_sel_q;
    bridge_type_e [NUM_TURFIO-1:0] bridge_type_q;
    logic [NUM_TURFIO-1:0]         invalid_q;
    logic [NUM_TURFIO-1:0]         invalid_clr;
    logic [REG_DATA_W-1:0]         rdata;

    assign invalid_clr = (wr_i && offs_i == ID_OFFS_BRIDGE_INVALID) ?
                         wdata_i[NUM_TURFIO-1:0] : '0;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            gpo_en_q      <= 1'b0;
            gpo_sel_q     <= GPO_SYNC;
            bridge_type_q <= {NUM_TURFIO{BRIDGE_NONE}};
            invalid_q     <= '0;
        end else begin
            if (wr_i && offs_i == ID_OFFS_CONTROL) begin
                gpo_sel_q <= gpo_sel_e'(wdata_i[2:0]);
                gpo_en_q  <= wdata_i[3];
            end
            if (wr_i && offs_i == ID_OFFS_BRIDGE_TYPE) begin
                for (int i = 0; i < NUM_TURFIO; i++) begin
                    bridge_type_q[i] <= bridge_type_e'(wdata_i[2*i +: 2]);
                end
            end
            // Set pulse beats the write-1-to-clear
            invalid_q <= (invalid_q & ~invalid_clr) | bridge_invalid_i;
        end
    end

    // Pending invalid pulses show up in the read so a back-to-back read sees them
    always_comb begin
        rdata = '0;
        hit_o = 1'b1;
        case (offs_i)
            ID_OFFS_IDENT:          rdata = TURF_IDENT;
            ID_OFFS_DATEVERSION:    rdata = TURF_DATEVERSION;
            ID_OFFS_CONTROL:        rdata[3:0] = {gpo_en_q, gpo_sel_q};
            ID_OFFS_BRIDGE_TYPE:    rdata[2*NUM_TURFIO-1:0] = bridge_type_q;
            ID_OFFS_BRIDGE_INVALID: rdata[NUM_TURFIO-1:0] = invalid_q | bridge_invalid_i;
            ID_OFFS_LINK_UP:        rdata[NUM_TURFIO-1:0] = link_up_i;
            default:                hit_o = 1'b0;
        endcase
    end

    assign rdata_o       = rd_i ? rdata : '0;
    assign bridge_type_o = bridge_type_q;
    assign gpo_en_o      = gpo_en_q;
    assign gpo_sel_o     = gpo_sel_q;

endmodule

// ==== verilog/crate_bridge_gate.sv ====
`timescale 1ns/1ps
module crate_bridge_gate import turf_io_pkg::*; (
    input  logic                          ps_clk,
    input  logic                          reset_i,
    input  crate_cmd_t                    cmd_i,
    input  logic                          wr_i,
    input  bridge_type_e [NUM_TURFIO-1:0] bridge_type_i,
    input  logic [NUM_TURFIO-1:0]         link_up_i,
    output logic                          done_o,
    output logic                          err_o,
    output logic [NUM_TURFIO-1:0]         invalid_o,
    output crate_cmd_t                    crate_cmd_o,
    output logic                          crate_valid_o,
    input  logic                          crate_ready_i
);

    bridge_type_e          sel_type;
    logic                  sel_link;
    logic                  type_ok;
    logic [NUM_TURFIO-1:0] invalid_q;

    assign sel_type = bridge_type_i[cmd_i.turfio];
    assign sel_link = link_up_i[cmd_i.turfio];

    // No bridge always completes; Aurora needs its link
    assign type_ok = (sel_type == BRIDGE_NONE) ||
                     (sel_type == BRIDGE_AURORA && sel_link);

    assign crate_cmd_o   = cmd_i;
    assign crate_valid_o = wr_i && type_ok && (sel_type == BRIDGE_AURORA);
    assign done_o        = wr_i && type_ok && (sel_type == BRIDGE_NONE || crate_ready_i);
    assign err_o         = wr_i && !type_ok;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            invalid_q <= '0;
        end else begin
            invalid_q <= '0;
            if (err_o) begin
                invalid_q[cmd_i.turfio] <= 1'b1;
            end
        end
    end

    assign invalid_o = invalid_q;

endmodule

// ==== verilog/gpo_mux.sv ====
`timescale 1ns/1ps
module gpo_mux import turf_io_pkg::*; (
    input  logic                       ps_clk,
    input  logic                       reset_i,
    input  logic                       gpo_en_i,
    input  gpo_sel_e                   gpo_sel_i,
    input  gpo_src_t [GPO_NUM_SRC-1:0] gpo_src_i,
    output logic                       gpo_o
);

    gpo_src_t src;
    logic     gpo_q;

    assign src = gpo_src_i[gpo_sel_i[1:0]];

    // Output holds between qualifying ce strobes
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            gpo_q <= 1'b0;
        end else if (!gpo_en_i || gpo_sel_i > GPO_PPS) begin
            gpo_q <= 1'b0;
        end else if (src.ce) begin
            gpo_q <= src.d;
        end
    end

    assign gpo_o = gpo_q;

endmodule

// ==== verilog/turf_reg_top.sv ====
`timescale 1ns/1ps
module turf_reg_top import turf_reg_pkg::*, turf_io_pkg::*; (
    input  logic                       ps_clk,
    input  logic                       reset_i,
    input  reg_req_t                   req_i,
    input  logic                       req_valid_i,
    output logic                       req_ready_o,
    output reg_resp_t                  resp_o,
    output logic                       resp_valid_o,
    input  logic                       resp_ready_i,
    output crate_cmd_t                 crate_cmd_o,
    output logic                       crate_valid_o,
    input  logic                       crate_ready_i,
    input  logic [NUM_TURFIO-1:0]      link_up_i,
    input  gpo_src_t [GPO_NUM_SRC-1:0] gpo_src_i,
    output logic                       gpo_o
);

    reg_req_t                      dec_req;
    logic                          dec_req_valid;
    logic                          dec_req_ready;
    reg_resp_t                     dec_resp;
    logic                          dec_resp_valid;
    logic                          dec_resp_ready;
    logic                          id_wr;
    logic                          id_rd;
    logic [ID_OFFS_W-1:0]          id_offs;
    logic [REG_DATA_W-1:0]         id_wdata;
    logic [REG_DATA_W-1:0]         id_rdata;
    logic                          id_hit;
    crate_cmd_t                    crate_req;
    logic                          crate_wr;
    logic                          crate_done;
    logic                          crate_err;
    bridge_type_e [NUM_TURFIO-1:0] bridge_type;
    logic [NUM_TURFIO-1:0]         bridge_invalid;
    logic                          gpo_en;
    gpo_sel_e                      gpo_sel;

    //////////////////////////////
    // Input side
    //////////////////////////////

    reg_skid_buffer #(.payload_t(reg_req_t)) u_req_skid (
        .ps_clk      (ps_clk),
        .reset_i     (reset_i),
        .in_i        (req_i),
        .in_valid_i  (req_valid_i),
        .in_ready_o  (req_ready_o),
        .out_o       (dec_req),
        .out_valid_o (dec_req_valid),
        .out_ready_i (dec_req_ready)
    );

    //////////////////////////////
    // Register processing
    //////////////////////////////

    reg_space_decode u_decode (
        .ps_clk       (ps_clk),
        .reset_i      (reset_i),
        .req_i        (dec_req),
        .req_valid_i  (dec_req_valid),
        .req_ready_o  (dec_req_ready),
        .resp_o       (dec_resp),
        .resp_valid_o (dec_resp_valid),
        .resp_ready_i (dec_resp_ready),
        .id_wr_o      (id_wr),
        .id_rd_o      (id_rd),
        .id_offs_o    (id_offs),
        .id_wdata_o   (id_wdata),
        .id_rdata_i   (id_rdata),
        .id_hit_i     (id_hit),
        .crate_req_o  (crate_req),
        .crate_wr_o   (crate_wr),
        .crate_done_i (crate_done),
        .crate_err_i  (crate_err)
    );

    id_ctrl_regs u_id_ctrl (
        .ps_clk           (ps_clk),
        .reset_i          (reset_i),
        .wr_i             (id_wr),
        .rd_i             (id_rd),
        .offs_i           (id_offs),
        .wdata_i          (id_wdata),
        .rdata_o          (id_rdata),
        .hit_o            (id_hit),
        .link_up_i        (link_up_i),
        .bridge_invalid_i (bridge_invalid),
        .bridge_type_o    (bridge_type),
        .gpo_en_o         (gpo_en),
        .gpo_sel_o        (gpo_sel)
    );

    crate_bridge_gate u_crate_gate (
        .ps_clk        (ps_clk),
        .reset_i       (reset_i),
        .cmd_i         (crate_req),
        .wr_i          (crate_wr),
        .bridge_type_i (bridge_type),
        .link_up_i     (link_up_i),
        .done_o        (crate_done),
        .err_o         (crate_err),
        .invalid_o     (bridge_invalid),
        .crate_cmd_o   (crate_cmd_o),
        .crate_valid_o (crate_valid_o),
        .crate_ready_i (crate_ready_i)
    );

    gpo_mux u_gpo_mux (
        .ps_clk    (ps_clk),
        .reset_i   (reset_i),
        .gpo_en_i  (gpo_en),
        .gpo_sel_i (gpo_sel),
        .gpo_src_i (gpo_src_i),
        .gpo_o     (gpo_o)
    );

    //////////////////////////////
    // Output side
    //////////////////////////////

    reg_skid_buffer #(.payload_t(reg_resp_t)) u_resp_skid (
        .ps_clk      (ps_clk),
        .reset_i     (reset_i),
        .in_i        (dec_resp),
        .in_valid_i  (dec_resp_valid),
        .in_ready_o  (dec_resp_ready),
        .out_o       (resp_o),
        .out_valid_o (resp_valid_o),
        .out_ready_i (resp_ready_i)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps
module tb_clock_gen (
    output logic ps_clk,
    output logic reset_o
);

    // 4 ns period
    initial begin
        ps_clk = 1'b0;
        forever begin
            #2 ps_clk = ~ps_clk;
        end
    end

    // Reset spans the first three rising edges
    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge ps_clk);
        #1;
        reset_o = 1'b0;
    end

endmodule

// ==== tests/tb_turf_reg_top.sv ====
`timescale 1ns/1ps
module tb_turf_reg_top import turf_reg_pkg::*, turf_io_pkg::*; ();

    localparam int TIMEOUT = 1000;

    logic                       ps_clk;
    logic                       reset_i;
    reg_req_t                   req_i;
    logic                       req_valid_i;
    logic                       req_ready_o;
    reg_resp_t                  resp_o;
    logic                       resp_valid_o;
    logic                       resp_ready_i;
    crate_cmd_t                 crate_cmd_o;
    logic                       crate_valid_o;
    logic                       crate_ready_i;
    logic [NUM_TURFIO-1:0]      link_up_i;
    gpo_src_t [GPO_NUM_SRC-1:0] gpo_src_i;
    logic                       gpo_o;

    // Reference model state
    logic [3:0]              m_ctrl;
    logic [2*NUM_TURFIO-1:0] m_btype;
    logic [NUM_TURFIO-1:0]   m_invalid;
    logic                    m_gpo;
    reg_resp_t               exp_resp_q[$];
    crate_cmd_t              exp_cmd_q[$];
    int                      accept_q[$];
    int                      cyc = 0;
    logic                    rand_ready = 1'b0;
    logic                    lat_check = 1'b0;

    tb_clock_gen u_clk (
        .ps_clk  (ps_clk),
        .reset_o (reset_i)
    );

    turf_reg_top u_dut (
        .ps_clk        (ps_clk),
        .reset_i       (reset_i),
        .req_i         (req_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .resp_o        (resp_o),
        .resp_valid_o  (resp_valid_o),
        .resp_ready_i  (resp_ready_i),
        .crate_cmd_o   (crate_cmd_o),
        .crate_valid_o (crate_valid_o),
        .crate_ready_i (crate_ready_i),
        .link_up_i     (link_up_i),
        .gpo_src_i     (gpo_src_i),
        .gpo_o         (gpo_o)
    );

    always @(posedge ps_clk) begin
        cyc <= cyc + 1;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_resp(input reg_resp_t got, input reg_resp_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED resp_o: got rdata=%h err=%h, expected rdata=%h err=%h",
                                    got.rdata, got.err, exp.rdata, exp.err));
        end
    endtask

    task automatic check_crate_cmd(input crate_cmd_t got, input crate_cmd_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED crate_cmd_o: got %h, expected %h", got, exp));
        end
    endtask

    task automatic check_gpo(input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED gpo_o: got %h, expected %h", got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("CHECK FAILED resp latency: got %h, expected %h", got, exp));
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Predicts one response in request order and queues any forwarded crate command
    task automatic predict(input reg_req_t r, output reg_resp_t e);
        logic [1:0]            t;
        logic [1:0]            bt;
        logic [ID_OFFS_W-1:0]  offs;
        logic [REG_DATA_W-1:0] rd;
        logic                  hit;
        crate_cmd_t            c;
        e.err   = 1'b1;
        e.rdata = ERR_RDATA;
        t       = r.addr[26:25];
        bt      = m_btype[2*t +: 2];
        offs    = r.addr[ID_OFFS_W-1:0];
        rd      = '0;
        hit     = 1'b1;
        if (r.addr[CRATE_SPACE_BIT]) begin
            // Crate reads always fail
            if (r.we && (bt == BRIDGE_NONE || (bt == BRIDGE_AURORA && link_up_i[t]))) begin
                e.err   = 1'b0;
                e.rdata = '0;
                if (bt == BRIDGE_AURORA) begin
                    c.turfio = t;
                    c.addr   = r.addr[CRATE_ADDR_W-1:0];
                    c.wdata  = r.wdata;
                    exp_cmd_q.push_back(c);
                end
            end else if (r.we) begin
                m_invalid[t] = 1'b1;
            end
        end else if (r.addr[ID_SPACE_TOP:ID_OFFS_W] == '0) begin
            case (offs)
                ID_OFFS_IDENT:       rd = TURF_IDENT;
                ID_OFFS_DATEVERSION: rd = TURF_DATEVERSION;
                ID_OFFS_CONTROL: begin
                    rd[3:0] = m_ctrl;
                    if (r.we) begin
                        m_ctrl = r.wdata[3:0];
                    end
                end
                ID_OFFS_BRIDGE_TYPE: begin
                    rd[2*NUM_TURFIO-1:0] = m_btype;
                    if (r.we) begin
                        m_btype = r.wdata[2*NUM_TURFIO-1:0];
                    end
                end
                ID_OFFS_BRIDGE_INVALID: begin
                    rd[NUM_TURFIO-1:0] = m_invalid;
                    if (r.we) begin
                        m_invalid = m_invalid & ~r.wdata[NUM_TURFIO-1:0];
                    end
                end
                ID_OFFS_LINK_UP:     rd[NUM_TURFIO-1:0] = link_up_i;
                default:             hit = 1'b0;
            endcase
            if (hit) begin
                e.err   = 1'b0;
                e.rdata = r.we ? '0 : rd;
            end
        end
    endtask

    // Value gpo_o takes at the next edge for the given sources
    function automatic logic gpo_next(input gpo_src_t [GPO_NUM_SRC-1:0] src);
        logic [2:0] sel;
        sel = m_ctrl[2:0];
        if (!m_ctrl[3] || sel > 3'd3) begin
            return 1'b0;
        end
        if (src[sel[1:0]].ce) begin
            return src[sel[1:0]].d;
        end
        return m_gpo;
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    function automatic reg_req_t id_req(input logic [ID_OFFS_W-1:0] offs, input logic we,
                                        input logic [REG_DATA_W-1:0] wdata);
        reg_req_t r;
        r.addr  = '0;
        r.addr[ID_OFFS_W-1:0] = offs;
        r.we    = we;
        r.wdata = wdata;
        return r;
    endfunction

    // Kinds: 0 ID read, 1 CONTROL write, 2 BRIDGE_TYPE write, 3 crate write,
    // 5 crate read, 6 unmapped ID offset, 7 outside both spaces
    function automatic reg_req_t make_req(input int kind);
        reg_req_t r;
        r = id_req('0, 1'b0, $urandom);
        case (kind)
            0: r.addr[ID_OFFS_W-1:0] = 14'(4 * $urandom_range(5, 0));
            1: r = id_req(ID_OFFS_CONTROL, 1'b1, $urandom);
            2: r = id_req(ID_OFFS_BRIDGE_TYPE, 1'b1, $urandom);
            3: begin
                r.addr = {1'b1, 27'($urandom)};
                r.we   = 1'b1;
            end
            5: r.addr = {1'b1, 27'($urandom)};
            6: begin
                r.addr[ID_OFFS_W-1:0] = 14'($urandom_range(16383, 24));
                r.we = 1'($urandom);
            end
            default: begin
                r.addr[ID_SPACE_TOP:ID_OFFS_W] = 13'($urandom_range(8191, 1));
                r.addr[ID_OFFS_W-1:0]          = 14'($urandom);
                r.we = 1'($urandom);
            end
        endcase
        return r;
    endfunction

    function automatic reg_req_t random_req();
        int k;
        k = $urandom_range(7, 0);
        return make_req(k == 4 ? 3 : k);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge ps_clk);
            #1;
        end
    endtask

    // Called 1 ns after a rising edge; returns 1 ns after the accepting edge
    task automatic send_req(input reg_req_t r);
        reg_resp_t e;
        int        waited;
        predict(r, e);
        exp_resp_q.push_back(e);
        req_i       = r;
        req_valid_i = 1'b1;
        waited      = 0;
        @(negedge ps_clk);
        while (!req_ready_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error("Request was never accepted by the DUT");
            end
            @(negedge ps_clk);
        end
        accept_q.push_back(cyc + 1);
        @(posedge ps_clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge ps_clk);
        while (exp_resp_q.size() != 0 || exp_cmd_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error("Expected responses or crate commands never arrived");
            end
            @(negedge ps_clk);
        end
        @(posedge ps_clk);
        #1;
    endtask

    task automatic do_access(input reg_req_t r);
        send_req(r);
        wait_drain();
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        @(negedge ps_clk);
        while (reset_i !== 1'b0) begin
            waited++;
            if (waited > 20) begin
                stop_on_error("Reset was never released");
            end
            @(negedge ps_clk);
        end
    endtask

    // Output side readies, random only while rand_ready is set
    always @(posedge ps_clk) begin
        #1;
        if (rand_ready) begin
            resp_ready_i  = ($urandom_range(3, 0) != 0);
            crate_ready_i = ($urandom_range(3, 0) != 0);
        end else begin
            resp_ready_i  = 1'b1;
            crate_ready_i = 1'b1;
        end
    end

    //////////////////////////////
    // Monitors
    //////////////////////////////

    always @(negedge ps_clk) begin : resp_monitor
        int acc;
        if (!reset_i && resp_valid_o && resp_ready_i) begin
            if (exp_resp_q.size() == 0) begin
                stop_on_error("Response arrived with none expected");
            end
            check_resp(resp_o, exp_resp_q.pop_front());
            acc = accept_q.pop_front();
            if (lat_check) begin
                check_latency(cyc + 1 - acc, 3);
            end
        end
    end

    always @(negedge ps_clk) begin : crate_monitor
        if (!reset_i && crate_valid_o && crate_ready_i) begin
            if (exp_cmd_q.size() == 0) begin
                stop_on_error("Crate command forwarded with none expected");
            end
            check_crate_cmd(crate_cmd_o, exp_cmd_q.pop_front());
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        void'($urandom(32'h146f));
        req_i         = '0;
        req_valid_i   = 1'b0;
        resp_ready_i  = 1'b1;
        crate_ready_i = 1'b1;
        link_up_i     = '0;
        gpo_src_i     = '0;
        m_ctrl        = '0;
        m_btype       = '0;
        m_invalid     = '0;
        m_gpo         = 1'b0;

        // Idle state after reset
        wait_reset();
        check_flag("resp_valid_o", resp_valid_o, 1'b0);
        check_flag("crate_valid_o", crate_valid_o, 1'b0);
        check_flag("req_ready_o", req_ready_o, 1'b1);
        check_gpo(gpo_o, 1'b0);
        @(posedge ps_clk);
        #1;
        do_access(id_req(ID_OFFS_IDENT, 1'b0, '0));
        do_access(id_req(ID_OFFS_DATEVERSION, 1'b0, '0));

        // Register readback and error decode
        link_up_i = 4'($urandom);
        repeat (20) begin
            do_access(make_req(1));
            do_access(id_req(ID_OFFS_CONTROL, 1'b0, '0));
            do_access(make_req(2));
            do_access(id_req(ID_OFFS_BRIDGE_TYPE, 1'b0, '0));
            do_access(id_req(ID_OFFS_LINK_UP, 1'b0, '0));
            do_access(make_req(6));
            do_access(make_req(7));
            do_access(make_req(5));
        end

        // Crate writes under random bridge types and links
        repeat (8) begin
            link_up_i = 4'($urandom);
            do_access(make_req(2));
            repeat (12) begin
                send_req(make_req(3));
            end
            send_req(id_req(ID_OFFS_BRIDGE_INVALID, 1'b0, '0));
            wait_drain();
            do_access(id_req(ID_OFFS_BRIDGE_INVALID, 1'b1, $urandom));
            do_access(id_req(ID_OFFS_BRIDGE_INVALID, 1'b0, '0));
        end

        // Back-pressure on both output ports
        link_up_i  = 4'($urandom);
        rand_ready = 1'b1;
        repeat (300) begin
            send_req(random_req());
            if ($urandom_range(3, 0) == 0) begin
                idle_cycles($urandom_range(3, 1));
            end
        end
        wait_drain();
        rand_ready = 1'b0;
        idle_cycles(2);

        // Fixed latency with both readies high
        lat_check = 1'b1;
        repeat (60) begin
            send_req(random_req());
        end
        wait_drain();
        lat_check = 1'b0;

        // GPO mux against random source streams
        repeat (16) begin
            do_access(make_req(1));
            if (!m_ctrl[3] || m_ctrl[2:0] > 3'd3) begin
                m_gpo = 1'b0;
            end
            check_gpo(gpo_o, m_gpo);
            repeat (40) begin
                gpo_src_i = 8'($urandom);
                m_gpo     = gpo_next(gpo_src_i);
                @(posedge ps_clk);
                #1;
                check_gpo(gpo_o, m_gpo);
            end
            gpo_src_i = '0;
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/turf_reg_pkg.sv
verilog/turf_io_pkg.sv
verilog/reg_skid_buffer.sv
verilog/reg_space_decode.sv
verilog/id_ctrl_regs.sv
verilog/crate_bridge_gate.sv
verilog/gpo_mux.sv
verilog/turf_reg_top.sv
tests/tb_clock_gen.sv
tests/tb_turf_reg_top.sv

// ==== Bender.yml ====
package:
  name: turf_reg

sources:
  - files:
      - verilog/turf_reg_pkg.sv
      - verilog/turf_io_pkg.sv
      - verilog/reg_skid_buffer.sv
      - verilog/reg_space_decode.sv
      - verilog/id_ctrl_regs.sv
      - verilog/crate_bridge_gate.sv
      - verilog/gpo_mux.sv
      - verilog/turf_reg_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_turf_reg_top.sv
